//--- design/soc_bus_pkg.sv
package soc_bus_pkg;

    // bus-side words and byte enables
    typedef logic [31:0] word_t;
    typedef logic [3:0]  mask_t;    // one bit per byte, active high

    // word address on the SRAM chip pins
    typedef logic [19:0] sram_addr_t;

    // where an access lands
    typedef enum logic [1:0] {
        REGION_NONE    = 2'd0,    // no request or unmapped
        REGION_BASE    = 2'd1,
        REGION_EXT     = 2'd2,
        REGION_DISPLAY = 2'd3
    } region_e;

    // SRAM access sequence
    typedef enum logic [1:0] {
        SRAM_IDLE  = 2'd0,
        SRAM_SETUP = 2'd1,    // address and strobes settle
        SRAM_HOLD  = 2'd2     // write pulse, read sample at the end
    } sram_state_e;

    // address map
    localparam word_t BASE_RAM_START = 32'h8000_0000;
    localparam word_t EXT_RAM_START  = 32'h8040_0000;
    localparam word_t BANK_BYTES     = 32'h0040_0000;    // 4 MiB per bank
    localparam word_t DISPLAY_ADDR   = 32'hBFD0_0400;

    // top bit of the byte offset inside a bank
    localparam int BANK_ADDR_MSB = 21;

    // bank slots in the arbiter's per-bank vectors
    localparam int BANK_BASE = 0;
    localparam int BANK_EXT  = 1;

    localparam mask_t FULL_MASK = 4'b1111;

endpackage

//--- design/bus_addr_decoder.sv
`timescale 1ns/100ps

module bus_addr_decoder (
    input  logic                 inst_re_i,
    input  soc_bus_pkg::word_t   inst_addr_i,
    input  logic                 data_re_i,
    input  logic                 data_we_i,
    input  soc_bus_pkg::word_t   data_addr_i,
    output soc_bus_pkg::region_e inst_region_o,
    output soc_bus_pkg::region_e data_region_o
);
    import soc_bus_pkg::*;

    logic data_req;

    // unsigned offset wraps for addresses below the window
    function automatic logic in_bank(word_t addr, word_t start);
        word_t offset;
        offset = addr - start;
        return offset < BANK_BYTES;
    endfunction

    assign data_req = data_re_i | data_we_i;

    // fetch side has no display window
    always_comb begin
        inst_region_o = REGION_NONE;
        if (inst_re_i) begin
            if (in_bank(inst_addr_i, BASE_RAM_START)) begin
                inst_region_o = REGION_BASE;
            end else if (in_bank(inst_addr_i, EXT_RAM_START)) begin
                inst_region_o = REGION_EXT;
            end
        end
    end

    always_comb begin
        data_region_o = REGION_NONE;
        if (data_req) begin
            if (in_bank(data_addr_i, BASE_RAM_START)) begin
                data_region_o = REGION_BASE;
            end else if (in_bank(data_addr_i, EXT_RAM_START)) begin
                data_region_o = REGION_EXT;
            end else if (data_addr_i == DISPLAY_ADDR) begin
                data_region_o = REGION_DISPLAY;    // single word
            end
        end
    end

endmodule

//--- design/bank_arbiter.sv
`timescale 1ns/100ps

module bank_arbiter (
    input  logic                 clk_25M,
    input  logic                 reset_i,
    input  logic                 inst_re_i,
    input  soc_bus_pkg::word_t   inst_addr_i,
    input  logic                 data_re_i,
    input  logic                 data_we_i,
    input  soc_bus_pkg::word_t   data_addr_i,
    input  soc_bus_pkg::word_t   data_wdata_i,
    input  soc_bus_pkg::mask_t   data_mask_i,
    input  soc_bus_pkg::region_e inst_region_i,
    input  soc_bus_pkg::region_e data_region_i,
    output logic                 base_start_o,
    output logic                 base_we_o,
    output soc_bus_pkg::word_t   base_addr_o,
    output soc_bus_pkg::word_t   base_wdata_o,
    output soc_bus_pkg::mask_t   base_mask_o,
    input  logic                 base_done_i,
    input  soc_bus_pkg::word_t   base_rdata_i,
    output logic                 ext_start_o,
    output logic                 ext_we_o,
    output soc_bus_pkg::word_t   ext_addr_o,
    output soc_bus_pkg::word_t   ext_wdata_o,
    output soc_bus_pkg::mask_t   ext_mask_o,
    input  logic                 ext_done_i,
    input  soc_bus_pkg::word_t   ext_rdata_i,
    output logic                 disp_we_o,
    output soc_bus_pkg::word_t   disp_wdata_o,
    output soc_bus_pkg::mask_t   disp_mask_o,
    input  soc_bus_pkg::word_t   disp_rdata_i,
    output soc_bus_pkg::word_t   inst_data_o,
    output soc_bus_pkg::word_t   data_rdata_o,
    output logic                 stall_o
);
    import soc_bus_pkg::*;

    logic       data_req;
    logic       disp_hit;
    logic [1:0] inst_hit;        // per bank
    logic [1:0] data_hit;
    logic [1:0] inst_wants;      // targeted and not yet served
    logic [1:0] data_wants;
    logic [1:0] inst_start;
    logic [1:0] data_start;
    logic [1:0] bank_done;
    logic [1:0] busy_q;          // access in flight on the bank
    logic [1:0] owner_q;         // 1 when the data port owns it
    logic       inst_served_q;
    logic       data_served_q;
    logic       inst_done_now;
    logic       data_done_now;
    logic       inst_complete;
    logic       data_complete;
    word_t      inst_bank_rdata;
    word_t      data_bank_rdata;
    word_t      inst_res_q;
    word_t      data_res_q;

    assign data_req = data_re_i | data_we_i;
    assign disp_hit = (data_region_i == REGION_DISPLAY);
    assign inst_hit = {inst_region_i == REGION_EXT, inst_region_i == REGION_BASE};
    assign data_hit = {data_region_i == REGION_EXT, data_region_i == REGION_BASE};

    assign inst_wants = {2{inst_re_i & ~inst_served_q}} & inst_hit;
    assign data_wants = {2{data_req & ~data_served_q}} & data_hit;

    // on a shared bank the data port goes first
    assign data_start = data_wants & ~busy_q;
    assign inst_start = inst_wants & ~busy_q & ~data_wants;

    assign bank_done     = {ext_done_i, base_done_i};
    assign data_done_now = |(bank_done & busy_q & owner_q);
    assign inst_done_now = |(bank_done & busy_q & ~owner_q);

    // bank fields follow whichever port is being started
    assign base_start_o = data_start[BANK_BASE] | inst_start[BANK_BASE];
    assign base_we_o    = data_wants[BANK_BASE] & data_we_i;
    assign base_addr_o  = data_wants[BANK_BASE] ? data_addr_i : inst_addr_i;
    assign base_wdata_o = data_wdata_i;
    assign base_mask_o  = data_wants[BANK_BASE] ? data_mask_i : FULL_MASK;

    assign ext_start_o = data_start[BANK_EXT] | inst_start[BANK_EXT];
    assign ext_we_o    = data_wants[BANK_EXT] & data_we_i;
    assign ext_addr_o  = data_wants[BANK_EXT] ? data_addr_i : inst_addr_i;
    assign ext_wdata_o = data_wdata_i;
    assign ext_mask_o  = data_wants[BANK_EXT] ? data_mask_i : FULL_MASK;

    // one write pulse per request, even across a long stall
    assign disp_we_o    = data_we_i & disp_hit & ~data_served_q;
    assign disp_wdata_o = data_wdata_i;
    assign disp_mask_o  = data_mask_i;

    // display, unmapped and idle ports finish at once
    assign inst_complete = inst_served_q | inst_done_now | (inst_hit == 2'b00);
    assign data_complete = data_served_q | data_done_now | (data_hit == 2'b00);
    assign stall_o       = ~(inst_complete & data_complete);

    assign inst_bank_rdata = inst_hit[BANK_EXT] ? ext_rdata_i : base_rdata_i;
    assign data_bank_rdata = data_hit[BANK_EXT] ? ext_rdata_i : base_rdata_i;

    assign inst_data_o = (inst_hit == 2'b00) ? '0 :
                         inst_done_now       ? inst_bank_rdata : inst_res_q;

    assign data_rdata_o = disp_hit            ? disp_rdata_i :
                          (data_hit == 2'b00) ? '0 :
                          data_done_now       ? data_bank_rdata : data_res_q;

    always_ff @(posedge clk_25M) begin
        if (reset_i) begin
            busy_q        <= 2'b00;
            owner_q       <= 2'b00;
            inst_served_q <= 1'b0;
            data_served_q <= 1'b0;
        end else begin
            busy_q  <= (busy_q & ~bank_done) | data_start | inst_start;
            owner_q <= data_start | (owner_q & ~inst_start);
            if (stall_o) begin
                inst_served_q <= inst_served_q | inst_done_now;
                data_served_q <= data_served_q | data_done_now | disp_we_o;
            end else begin
                inst_served_q <= 1'b0;    // request retired
                data_served_q <= 1'b0;
            end
        end
    end

    // bank rdata may be overwritten by the next access on that bank
    always_ff @(posedge clk_25M) begin
        if (inst_done_now) begin
            inst_res_q <= inst_bank_rdata;
        end
        if (data_done_now) begin
            data_res_q <= data_bank_rdata;
        end
    end

endmodule

//--- design/sram_controller.sv
`timescale 1ns/100ps

module sram_controller (
    input  logic                    clk_25M,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  logic                    we_i,
    input  soc_bus_pkg::word_t      addr_i,
    input  soc_bus_pkg::word_t      wdata_i,
    input  soc_bus_pkg::mask_t      mask_i,
    output logic                    done_o,
    output soc_bus_pkg::word_t      rdata_o,
    output soc_bus_pkg::sram_addr_t sram_addr_o,
    output soc_bus_pkg::mask_t      be_n_o,
    output logic                    ce_n_o,
    output logic                    oe_n_o,
    output logic                    we_n_o,
    output soc_bus_pkg::word_t      data_o,
    output logic                    data_oe_o,
    input  soc_bus_pkg::word_t      data_i
);
    import soc_bus_pkg::*;

    sram_state_e state_q;
    sram_state_e state_d;
    logic        accept;
    logic        active;
    logic        done_q;
    logic        we_q;
    sram_addr_t  addr_q;
    word_t       wdata_q;
    mask_t       mask_q;
    word_t       rdata_q;

    assign accept = (state_q == SRAM_IDLE) & start_i;
    assign active = (state_q != SRAM_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            SRAM_IDLE: begin
                if (start_i) begin
                    state_d = SRAM_SETUP;
                end
            end
            SRAM_SETUP: state_d = SRAM_HOLD;
            SRAM_HOLD:  state_d = SRAM_IDLE;
            default:    state_d = SRAM_IDLE;
        endcase
    end

    always_ff @(posedge clk_25M) begin
        if (reset_i) begin
            state_q <= SRAM_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == SRAM_HOLD);    // lines up with rdata_q
        end
    end

    // request is frozen for the whole access
    always_ff @(posedge clk_25M) begin
        if (accept) begin
            we_q    <= we_i;
            addr_q  <= addr_i[BANK_ADDR_MSB:2];    // byte offset to word
            wdata_q <= wdata_i;
            mask_q  <= mask_i;
        end
        if (state_q == SRAM_HOLD && !we_q) begin
            rdata_q <= data_i;
        end
    end

    assign done_o  = done_q;
    assign rdata_o = rdata_q;

    // chip pins, all strobes active low
    assign sram_addr_o = addr_q;
    assign be_n_o      = active ? ~mask_q : '1;
    assign ce_n_o      = ~active;
    assign oe_n_o      = ~(active & ~we_q);
    assign we_n_o      = ~((state_q == SRAM_HOLD) & we_q);    // pulse in HOLD only
    assign data_o      = wdata_q;
    assign data_oe_o   = active & we_q;

endmodule

//--- design/display_regs.sv
`timescale 1ns/100ps

module display_regs (
    input  logic               clk_25M,
    input  logic               reset_i,
    input  logic               we_i,
    input  soc_bus_pkg::word_t wdata_i,
    input  soc_bus_pkg::mask_t mask_i,
    output soc_bus_pkg::word_t rdata_o,
    output logic [15:0]        leds_o
);
    import soc_bus_pkg::*;

    word_t word_q;

    // byte lanes update independently
    always_ff @(posedge clk_25M) begin
        if (reset_i) begin
            word_q <= '0;    // leds dark after reset
        end else if (we_i) begin
            for (int i = 0; i < $bits(mask_t); i++) begin
                if (mask_i[i]) begin
                    word_q[8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    assign rdata_o = word_q;          // full word readback
    assign leds_o  = word_q[15:0];

endmodule

//--- design/soc_bus_top.sv
`timescale 1ns/100ps

module soc_bus_top (
    input  logic                    clk_25M,
    input  logic                    reset_i,
    input  logic                    inst_re_i,
    input  soc_bus_pkg::word_t      inst_addr_i,
    output soc_bus_pkg::word_t      inst_data_o,
    input  logic                    data_re_i,
    input  logic                    data_we_i,
    input  soc_bus_pkg::word_t      data_addr_i,
    input  soc_bus_pkg::word_t      data_wdata_i,
    input  soc_bus_pkg::mask_t      data_mask_i,
    output soc_bus_pkg::word_t      data_rdata_o,
    output logic                    stall_o,
    output soc_bus_pkg::sram_addr_t base_ram_addr_o,
    output soc_bus_pkg::mask_t      base_ram_be_n_o,
    output logic                    base_ram_ce_n_o,
    output logic                    base_ram_oe_n_o,
    output logic                    base_ram_we_n_o,
    output soc_bus_pkg::word_t      base_ram_data_o,
    output logic                    base_ram_data_oe_o,
    input  soc_bus_pkg::word_t      base_ram_data_i,
    output soc_bus_pkg::sram_addr_t ext_ram_addr_o,
    output soc_bus_pkg::mask_t      ext_ram_be_n_o,
    output logic                    ext_ram_ce_n_o,
    output logic                    ext_ram_oe_n_o,
    output logic                    ext_ram_we_n_o,
    output soc_bus_pkg::word_t      ext_ram_data_o,
    output logic                    ext_ram_data_oe_o,
    input  soc_bus_pkg::word_t      ext_ram_data_i,
    output logic [15:0]             leds_o
);
    import soc_bus_pkg::*;

    region_e inst_region;
    region_e data_region;

    // base bank request and return
    logic  base_start;
    logic  base_we;
    word_t base_addr;
    word_t base_wdata;
    mask_t base_mask;
    logic  base_done;
    word_t base_rdata;

    // ext bank request and return
    logic  ext_start;
    logic  ext_we;
    word_t ext_addr;
    word_t ext_wdata;
    mask_t ext_mask;
    logic  ext_done;
    word_t ext_rdata;

    logic  disp_we;
    word_t disp_wdata;
    mask_t disp_mask;
    word_t disp_rdata;

    bus_addr_decoder i_decoder (
        .inst_re_i     (inst_re_i),
        .inst_addr_i   (inst_addr_i),
        .data_re_i     (data_re_i),
        .data_we_i     (data_we_i),
        .data_addr_i   (data_addr_i),
        .inst_region_o (inst_region),
        .data_region_o (data_region)
    );

    bank_arbiter i_arbiter (
        .clk_25M       (clk_25M),
        .reset_i       (reset_i),
        .inst_re_i     (inst_re_i),
        .inst_addr_i   (inst_addr_i),
        .data_re_i     (data_re_i),
        .data_we_i     (data_we_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_mask_i   (data_mask_i),
        .inst_region_i (inst_region),
        .data_region_i (data_region),
        .base_start_o  (base_start),
        .base_we_o     (base_we),
        .base_addr_o   (base_addr),
        .base_wdata_o  (base_wdata),
        .base_mask_o   (base_mask),
        .base_done_i   (base_done),
        .base_rdata_i  (base_rdata),
        .ext_start_o   (ext_start),
        .ext_we_o      (ext_we),
        .ext_addr_o    (ext_addr),
        .ext_wdata_o   (ext_wdata),
        .ext_mask_o    (ext_mask),
        .ext_done_i    (ext_done),
        .ext_rdata_i   (ext_rdata),
        .disp_we_o     (disp_we),
        .disp_wdata_o  (disp_wdata),
        .disp_mask_o   (disp_mask),
        .disp_rdata_i  (disp_rdata),
        .inst_data_o   (inst_data_o),
        .data_rdata_o  (data_rdata_o),
        .stall_o       (stall_o)
    );

    sram_controller i_base_sram (
        .clk_25M     (clk_25M),
        .reset_i     (reset_i),
        .start_i     (base_start),
        .we_i        (base_we),
        .addr_i      (base_addr),
        .wdata_i     (base_wdata),
        .mask_i      (base_mask),
        .done_o      (base_done),
        .rdata_o     (base_rdata),
        .sram_addr_o (base_ram_addr_o),
        .be_n_o      (base_ram_be_n_o),
        .ce_n_o      (base_ram_ce_n_o),
        .oe_n_o      (base_ram_oe_n_o),
        .we_n_o      (base_ram_we_n_o),
        .data_o      (base_ram_data_o),
        .data_oe_o   (base_ram_data_oe_o),
        .data_i      (base_ram_data_i)
    );

    sram_controller i_ext_sram (
        .clk_25M     (clk_25M),
        .reset_i     (reset_i),
        .start_i     (ext_start),
        .we_i        (ext_we),
        .addr_i      (ext_addr),
        .wdata_i     (ext_wdata),
        .mask_i      (ext_mask),
        .done_o      (ext_done),
        .rdata_o     (ext_rdata),
        .sram_addr_o (ext_ram_addr_o),
        .be_n_o      (ext_ram_be_n_o),
        .ce_n_o      (ext_ram_ce_n_o),
        .oe_n_o      (ext_ram_oe_n_o),
        .we_n_o      (ext_ram_we_n_o),
        .data_o      (ext_ram_data_o),
        .data_oe_o   (ext_ram_data_oe_o),
        .data_i      (ext_ram_data_i)
    );

    display_regs i_display (
        .clk_25M (clk_25M),
        .reset_i (reset_i),
        .we_i    (disp_we),
        .wdata_i (disp_wdata),
        .mask_i  (disp_mask),
        .rdata_o (disp_rdata),
        .leds_o  (leds_o)
    );

endmodule

//--- verif/soc_bus_assertions.sv
`timescale 1ns/100ps

module soc_bus_assertions (
    input logic clk_25M,
    input logic reset_i,
    input logic stall_o,
    input logic base_ram_ce_n_o,
    input logic base_ram_oe_n_o,
    input logic base_ram_we_n_o,
    input logic base_ram_data_oe_o,
    input logic ext_ram_ce_n_o,
    input logic ext_ram_oe_n_o,
    input logic ext_ram_we_n_o,
    input logic ext_ram_data_oe_o
);

    int unsigned fail_count = 0;    // read by the testbench
    logic        strobes_idle;

    assign strobes_idle = base_ram_ce_n_o & base_ram_oe_n_o & base_ram_we_n_o
                        & ~base_ram_data_oe_o & ext_ram_ce_n_o & ext_ram_oe_n_o
                        & ext_ram_we_n_o & ~ext_ram_data_oe_o;

    // strobes only inside a chip select
    base_strobe_in_ce: assert property (@(posedge clk_25M) disable iff (reset_i)
        (!base_ram_oe_n_o || !base_ram_we_n_o) |-> !base_ram_ce_n_o)
        else begin
            fail_count++;
            $error("base bank strobe low while ce_n is high");
        end

    ext_strobe_in_ce: assert property (@(posedge clk_25M) disable iff (reset_i)
        (!ext_ram_oe_n_o || !ext_ram_we_n_o) |-> !ext_ram_ce_n_o)
        else begin
            fail_count++;
            $error("ext bank strobe low while ce_n is high");
        end

    base_no_bus_fight: assert property (@(posedge clk_25M) disable iff (reset_i)
        base_ram_we_n_o || base_ram_oe_n_o)
        else begin
            fail_count++;
            $error("base bank we_n and oe_n low together");
        end

    ext_no_bus_fight: assert property (@(posedge clk_25M) disable iff (reset_i)
        ext_ram_we_n_o || ext_ram_oe_n_o)
        else begin
            fail_count++;
            $error("ext bank we_n and oe_n low together");
        end

    base_write_drives: assert property (@(posedge clk_25M) disable iff (reset_i)
        !base_ram_we_n_o |-> base_ram_data_oe_o)
        else begin
            fail_count++;
            $error("base bank write pulse without data drive");
        end

    ext_write_drives: assert property (@(posedge clk_25M) disable iff (reset_i)
        !ext_ram_we_n_o |-> ext_ram_data_oe_o)
        else begin
            fail_count++;
            $error("ext bank write pulse without data drive");
        end

    // first cycle out of reset
    idle_after_reset: assert property (@(posedge clk_25M)
        $fell(reset_i) |-> !stall_o && strobes_idle)
        else begin
            fail_count++;
            $error("bus not idle after reset");
        end

endmodule

bind soc_bus_top soc_bus_assertions i_assertions (.*);

//--- verif/tb_soc_bus.sv
`timescale 1ns/100ps

module tb_soc_bus;
    import soc_bus_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int NUM_RAND     = 8;    // offsets shared by both banks
    localparam int NUM_DISP     = 4;
    localparam int NUM_UNMAP    = 4;
    localparam int NUM_ACCESSES = 8 * NUM_RAND + 2 * NUM_DISP + NUM_UNMAP;
    localparam int WATCHDOG_NS  = 40 * (NUM_ACCESSES + 1) * 2 * CLK_HALF;

    logic        clk_25M = 1'b0;
    logic        reset_i;
    logic        inst_re_i;
    word_t       inst_addr_i;
    word_t       inst_data_o;
    logic        data_re_i;
    logic        data_we_i;
    word_t       data_addr_i;
    word_t       data_wdata_i;
    mask_t       data_mask_i;
    word_t       data_rdata_o;
    logic        stall_o;
    sram_addr_t  base_ram_addr_o;
    mask_t       base_ram_be_n_o;
    logic        base_ram_ce_n_o;
    logic        base_ram_oe_n_o;
    logic        base_ram_we_n_o;
    word_t       base_ram_data_o;
    logic        base_ram_data_oe_o;
    word_t       base_ram_data_i;
    sram_addr_t  ext_ram_addr_o;
    mask_t       ext_ram_be_n_o;
    logic        ext_ram_ce_n_o;
    logic        ext_ram_oe_n_o;
    logic        ext_ram_we_n_o;
    word_t       ext_ram_data_o;
    logic        ext_ram_data_oe_o;
    word_t       ext_ram_data_i;
    logic [15:0] leds_o;

    word_t base_mem [2**20];
    word_t ext_mem [2**20];
    word_t ref_mem [word_t];    // expected words by byte address
    word_t offs [NUM_RAND];
    word_t rng = 32'h3559;
    word_t inst_word;           // results of the last access
    word_t data_word;
    logic  base_ce_seen = 1'b0;    // chip select seen since last clear
    logic  ext_ce_seen  = 1'b0;

    soc_bus_top i_dut (.*);

    always #CLK_HALF clk_25M = ~clk_25M;

    // byte writes to the SRAM models land mid-pulse
    always @(negedge clk_25M) begin
        for (int i = 0; i < 4; i++) begin
            if (!base_ram_ce_n_o && !base_ram_we_n_o && !base_ram_be_n_o[i]) begin
                base_mem[base_ram_addr_o][8*i +: 8] = base_ram_data_o[8*i +: 8];
            end
            if (!ext_ram_ce_n_o && !ext_ram_we_n_o && !ext_ram_be_n_o[i]) begin
                ext_mem[ext_ram_addr_o][8*i +: 8] = ext_ram_data_o[8*i +: 8];
            end
        end
    end

    always @(negedge clk_25M) begin
        if (!base_ram_ce_n_o) begin
            base_ce_seen = 1'b1;
        end
        if (!ext_ram_ce_n_o) begin
            ext_ce_seen = 1'b1;
        end
    end

    assign base_ram_data_i = (base_ram_ce_n_o | base_ram_oe_n_o) ? 'x : base_mem[base_ram_addr_o];
    assign ext_ram_data_i  = (ext_ram_ce_n_o | ext_ram_oe_n_o) ? 'x : ext_mem[ext_ram_addr_o];

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function word_t rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    // power-up contents of a bank word tagged per bank
    function automatic word_t fill_word(input word_t addr);
        return {(addr >= EXT_RAM_START) ? 12'he57 : 12'hba5, addr[21:2]};
    endfunction

    function automatic word_t expected(input word_t addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return (addr == DISPLAY_ADDR) ? '0 : fill_word(addr);    // display resets to zero
    endfunction

    function automatic void ref_write(input word_t addr, input word_t wdata, input mask_t mask);
        word_t w;
        w = expected(addr);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                w[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        ref_mem[addr] = w;
    endfunction

    task automatic abort_run(input string why);
        $display("RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            abort_run("value mismatch");
        end
    endtask

    // requests stay put until stall_o drops
    task automatic access(input logic ire, input word_t iaddr, input logic dre,
                          input logic dwe, input word_t daddr, input word_t wdata,
                          input mask_t mask);
        @(posedge clk_25M);
        inst_re_i    <= ire;
        inst_addr_i  <= iaddr;
        data_re_i    <= dre;
        data_we_i    <= dwe;
        data_addr_i  <= daddr;
        data_wdata_i <= wdata;
        data_mask_i  <= mask;
        @(negedge clk_25M);
        while (stall_o) begin
            @(negedge clk_25M);
        end
        inst_word = inst_data_o;    // sampled mid-cycle
        data_word = data_rdata_o;
    endtask

    task automatic write_data(input word_t addr, input word_t wdata, input mask_t mask);
        access(1'b0, '0, 1'b0, 1'b1, addr, wdata, mask);
        ref_write(addr, wdata, mask);
    endtask

    task automatic read_data(input word_t addr);
        access(1'b0, '0, 1'b1, 1'b0, addr, '0, FULL_MASK);
        check_word("data_rdata_o", expected(addr), data_word);
    endtask

    // fetch and data read presented in the same cycle
    task automatic fetch_and_read(input word_t iaddr, input word_t daddr);
        access(1'b1, iaddr, 1'b1, 1'b0, daddr, '0, FULL_MASK);
        check_word("inst_data_o", expected(iaddr), inst_word);
        check_word("data_rdata_o", expected(daddr), data_word);
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("timeout: accesses did not complete within %0d ns", WATCHDOG_NS);
        abort_run("watchdog expired");
    end

    always @(negedge clk_25M) begin
        if (i_dut.i_assertions.fail_count != 0) begin
            abort_run("bound protocol assertion failed");
        end
    end

    initial begin
        word_t addr;
        word_t wdata;
        mask_t mask;
        word_t disp_exp;

        reset_i      = 1'b1;
        inst_re_i    = 1'b0;
        inst_addr_i  = '0;
        data_re_i    = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        data_mask_i  = '0;
        for (int i = 0; i < 2**20; i++) begin
            base_mem[i] = fill_word(BASE_RAM_START + 4 * i);
            ext_mem[i]  = fill_word(EXT_RAM_START + 4 * i);
        end
        repeat (3) @(posedge clk_25M);
        reset_i <= 1'b0;

        for (int i = 0; i < NUM_RAND; i++) begin
            offs[i] = rand_word() & (BANK_BYTES - 4);    // word aligned inside a bank
            write_data(BASE_RAM_START + offs[i], rand_word(), mask_t'(rand_word()));
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            write_data(EXT_RAM_START + offs[i], rand_word(), mask_t'(rand_word()));
        end
        // same offsets so a leak between banks shows up here
        for (int i = 0; i < NUM_RAND; i++) begin
            read_data(BASE_RAM_START + offs[i]);
            read_data(EXT_RAM_START + offs[i]);
        end

        for (int i = 0; i < NUM_RAND; i++) begin
            fetch_and_read(BASE_RAM_START + offs[i], EXT_RAM_START + offs[i]);
            fetch_and_read(EXT_RAM_START + offs[i], BASE_RAM_START + offs[i]);
            fetch_and_read(BASE_RAM_START + offs[i],
                           BASE_RAM_START + offs[(i + 1) % NUM_RAND]);    // bank conflict
        end

        // write goes first so the fetch sees the new bytes
        for (int i = 0; i < NUM_RAND; i++) begin
            addr  = ((i % 2) ? EXT_RAM_START : BASE_RAM_START) + offs[i];
            wdata = rand_word();
            mask  = mask_t'(rand_word());
            access(1'b1, addr, 1'b0, 1'b1, addr, wdata, mask);
            ref_write(addr, wdata, mask);
            check_word("inst_data_o", expected(addr), inst_word);
        end

        for (int i = 0; i < NUM_DISP; i++) begin
            write_data(DISPLAY_ADDR, rand_word(), mask_t'(rand_word()));
            read_data(DISPLAY_ADDR);
            disp_exp = expected(DISPLAY_ADDR);
            check_word("leds_o", {16'h0, disp_exp[15:0]}, {16'h0, leds_o});
        end

        // a fetch from the display word counts as unmapped
        base_ce_seen = 1'b0;
        ext_ce_seen  = 1'b0;
        for (int i = 0; i < NUM_UNMAP; i++) begin
            addr        = rand_word();
            addr[31:28] = 4'h1;
            access(1'b1, DISPLAY_ADDR, 1'b1, 1'b0, addr, '0, FULL_MASK);
            check_word("inst_data_o", '0, inst_word);
            check_word("data_rdata_o", '0, data_word);
            assert (!base_ce_seen) else begin
                abort_run("base bank selected during an unmapped access");
            end
            assert (!ext_ce_seen) else begin
                abort_run("ext bank selected during an unmapped access");
            end
        end

        @(posedge clk_25M);
        inst_re_i <= 1'b0;
        data_re_i <= 1'b0;
        data_we_i <= 1'b0;
        repeat (2) @(posedge clk_25M);
        if (i_dut.i_assertions.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("bound protocol assertion failed");
        end
    end

endmodule

//--- verilog.f
design/soc_bus_pkg.sv
design/bus_addr_decoder.sv
design/bank_arbiter.sv
design/sram_controller.sv
design/display_regs.sv
design/soc_bus_top.sv
verif/soc_bus_assertions.sv
verif/tb_soc_bus.sv
